//--- logic/physMemPkg.sv
package physMemPkg;

    // line geometry
    localparam int ADDR_BITS   = 32;
    localparam int LINE_BITS   = 256;
    localparam int LINE_OFFSET = 5;
    localparam int LINE_COUNT  = 64;
    localparam int INDEX_BITS  = 6;

    // request latency in cycles, zero is handled as one
    localparam int LATENCY_BITS = 16;
    localparam logic [LATENCY_BITS-1:0] DEFAULT_LATENCY = 16'd25;

    // sequencer states
    localparam logic [1:0] ST_IDLE    = 2'd0;
    localparam logic [1:0] ST_BUSY    = 2'd1;
    localparam logic [1:0] ST_RECOVER = 2'd2;

    // AXI4-Lite register map
    localparam int AXI_ADDR_BITS = 4;
    localparam int AXI_DATA_BITS = 32;
    localparam logic [AXI_ADDR_BITS-1:0] REG_LATENCY     = 4'h0;
    localparam logic [AXI_ADDR_BITS-1:0] REG_STATUS      = 4'h4;
    localparam logic [AXI_ADDR_BITS-1:0] REG_READ_COUNT  = 4'h8;
    localparam logic [AXI_ADDR_BITS-1:0] REG_WRITE_COUNT = 4'hC;
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // five causes need three bits
    typedef enum logic [2:0] {
        CAUSE_NONE          = 3'd0,
        CAUSE_READ_DROPPED  = 3'd1,
        CAUSE_WRITE_DROPPED = 3'd2,
        CAUSE_CONFLICT      = 3'd3,
        CAUSE_ADDR_CHANGED  = 3'd4
    } errCause;

endpackage

//--- logic/lineStore.sv
`timescale 1ns/1ps

module lineStore
    import physMemPkg::*;
(
    input  logic                  clk,
    input  logic                  storeWrite,
    input  logic [INDEX_BITS-1:0] storeIndex,
    input  logic [LINE_BITS-1:0]  storeWdata,
    output logic [LINE_BITS-1:0]  storeRdata
);

    // one full cache line per entry
    logic [LINE_BITS-1:0] lines [LINE_COUNT];

    // write port
    always_ff @(posedge clk) begin
        if (storeWrite) begin
            lines[storeIndex] <= storeWdata;
        end
    end

    // registered read, returns the old line on a same-edge write
    always_ff @(posedge clk) begin
        storeRdata <= lines[storeIndex];
    end

endmodule

//--- logic/lineAccessSequencer.sv
`timescale 1ns/1ps

module lineAccessSequencer
    import physMemPkg::*;
(
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    read,
    input  logic                    write,
    input  logic [ADDR_BITS-1:0]    address,
    input  logic [LINE_BITS-1:0]    wdata,
    input  logic [LATENCY_BITS-1:0] latency,
    output logic                    resp,
    output logic [LINE_BITS-1:0]    rdata,
    output logic                    readDone,
    output logic                    writeDone,
    output logic                    protoError,
    output errCause                 protoCause,
    output logic                    storeWrite,
    output logic [INDEX_BITS-1:0]   storeIndex,
    output logic [LINE_BITS-1:0]    storeWdata,
    input  logic [LINE_BITS-1:0]    storeRdata
);

    logic [1:0]              state;
    logic                    capRead;
    logic [ADDR_BITS-1:0]    capAddr;
    logic [LINE_BITS-1:0]    capLine;
    logic [LATENCY_BITS-1:0] countdown;
    logic                    accept;
    logic                    violation;
    logic                    lastCycle;
    errCause                 cause;

    assign accept = (state == ST_IDLE) && (read || write);

    // protocol check against the captured request
    always_comb begin
        cause = CAUSE_NONE;
        if (capRead) begin
            if (!read) begin
                cause = CAUSE_READ_DROPPED;
            end else if (write) begin
                cause = CAUSE_CONFLICT;
            end else if (address != capAddr) begin
                cause = CAUSE_ADDR_CHANGED;
            end
        end else begin
            if (!write) begin
                cause = CAUSE_WRITE_DROPPED;
            end else if (read) begin
                cause = CAUSE_CONFLICT;
            end else if (address != capAddr) begin
                cause = CAUSE_ADDR_CHANGED;
            end
        end
    end

    assign violation = (state == ST_BUSY) && (cause != CAUSE_NONE);
    assign lastCycle = (state == ST_BUSY) && (countdown == LATENCY_BITS'(1));

    // index is stable for the whole busy period, so the registered
    // store output lines up with resp
    assign storeIndex = capAddr[LINE_OFFSET +: INDEX_BITS];
    assign storeWdata = capLine;
    assign storeWrite = lastCycle && !capRead && !violation;
    assign rdata      = storeRdata;

    // request payload
    always_ff @(posedge clk) begin
        if (accept) begin
            capAddr <= address;
            capLine <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state      <= ST_IDLE;
            capRead    <= 1'b0;
            countdown  <= '0;
            resp       <= 1'b0;
            readDone   <= 1'b0;
            writeDone  <= 1'b0;
            protoError <= 1'b0;
            protoCause <= CAUSE_NONE;
        end else begin
            resp       <= 1'b0;
            readDone   <= 1'b0;
            writeDone  <= 1'b0;
            protoError <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (accept) begin
                        state   <= ST_BUSY;
                        // read wins if both rise together; the conflict check aborts it
                        capRead <= read;
                        countdown <= (latency == '0) ? LATENCY_BITS'(1) : latency;
                    end
                end
                ST_BUSY: begin
                    if (violation) begin
                        state      <= ST_RECOVER;
                        protoError <= 1'b1;
                        protoCause <= cause;
                    end else if (lastCycle) begin
                        state     <= ST_RECOVER;
                        resp      <= 1'b1;
                        readDone  <= capRead;
                        writeDone <= !capRead;
                    end else begin
                        countdown <= countdown - LATENCY_BITS'(1);
                    end
                end
                // the requester may still hold its request here
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

//--- logic/memConfigRegs.sv
`timescale 1ns/1ps

module memConfigRegs
    import physMemPkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic [AXI_ADDR_BITS-1:0]   awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [AXI_DATA_BITS-1:0]   axiWdata,
    input  logic [AXI_DATA_BITS/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [AXI_ADDR_BITS-1:0]   araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [AXI_DATA_BITS-1:0]   axiRdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready,
    input  logic                       readDone,
    input  logic                       writeDone,
    input  logic                       protoError,
    input  errCause                    protoCause,
    output logic [LATENCY_BITS-1:0]    latency,
    output logic                       error
);

    errCause                  causeReg;
    logic [AXI_DATA_BITS-1:0] readCount;
    logic [AXI_DATA_BITS-1:0] writeCount;
    logic                     writeFire;
    logic                     readFire;
    logic                     writeMapped;
    logic                     readMapped;
    logic                     clearError;
    logic [AXI_DATA_BITS-1:0] readWord;

    assign writeFire = awvalid && awready && wvalid && wready;
    assign readFire  = arvalid && arready;

    assign writeMapped = (awaddr == REG_LATENCY) || (awaddr == REG_STATUS) ||
                         (awaddr == REG_READ_COUNT) || (awaddr == REG_WRITE_COUNT);
    assign clearError  = writeFire && (awaddr == REG_STATUS) && wstrb[0] && axiWdata[0];

    // read decode, unmapped offsets return zero
    always_comb begin
        readMapped = 1'b1;
        readWord   = '0;
        case (araddr)
            REG_LATENCY:     readWord = AXI_DATA_BITS'(latency);
            REG_STATUS:      readWord = AXI_DATA_BITS'({causeReg, error});
            REG_READ_COUNT:  readWord = readCount;
            REG_WRITE_COUNT: readWord = writeCount;
            default:         readMapped = 1'b0;
        endcase
    end

    // write channel: both valids first, then a one-cycle ready pair
    always_ff @(posedge clk) begin
        if (!rstN) begin
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            bresp   <= RESP_OKAY;
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (awvalid && wvalid && !awready && !bvalid) begin
                awready <= 1'b1;
                wready  <= 1'b1;
            end
            if (writeFire) begin
                bvalid <= 1'b1;
                bresp  <= writeMapped ? RESP_OKAY : RESP_SLVERR;
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // read channel
    always_ff @(posedge clk) begin
        if (!rstN) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rresp   <= RESP_OKAY;
        end else begin
            arready <= 1'b0;
            if (arvalid && !arready && !rvalid) begin
                arready <= 1'b1;
            end
            if (readFire) begin
                rvalid <= 1'b1;
                rresp  <= readMapped ? RESP_OKAY : RESP_SLVERR;
            end else if (rvalid && rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (readFire) begin
            axiRdata <= readWord;
        end
    end

    // registers and counters
    always_ff @(posedge clk) begin
        if (!rstN) begin
            latency    <= DEFAULT_LATENCY;
            error      <= 1'b0;
            causeReg   <= CAUSE_NONE;
            readCount  <= '0;
            writeCount <= '0;
        end else begin
            if (writeFire && (awaddr == REG_LATENCY)) begin
                for (int b = 0; b < LATENCY_BITS / 8; b++) begin
                    if (wstrb[b]) begin
                        latency[b*8 +: 8] <= axiWdata[b*8 +: 8];
                    end
                end
            end
            if (clearError) begin
                error    <= 1'b0;
                causeReg <= CAUSE_NONE;
            end
            // a new violation beats a clear in the same cycle
            if (protoError) begin
                error <= 1'b1;
                if (!error || clearError) begin
                    causeReg <= protoCause;
                end
            end
            if (readDone) begin
                readCount <= readCount + 1'b1;
            end
            if (writeDone) begin
                writeCount <= writeCount + 1'b1;
            end
        end
    end

endmodule

//--- logic/physMemTop.sv
`timescale 1ns/1ps

module physMemTop
    import physMemPkg::*;
(
    input  logic                       clk,
    input  logic                       rstN,
    input  logic                       read,
    input  logic                       write,
    input  logic [ADDR_BITS-1:0]       address,
    input  logic [LINE_BITS-1:0]       wdata,
    output logic                       resp,
    output logic [LINE_BITS-1:0]       rdata,
    output logic                       error,
    input  logic [AXI_ADDR_BITS-1:0]   awaddr,
    input  logic                       awvalid,
    output logic                       awready,
    input  logic [AXI_DATA_BITS-1:0]   axiWdata,
    input  logic [AXI_DATA_BITS/8-1:0] wstrb,
    input  logic                       wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  logic                       bready,
    input  logic [AXI_ADDR_BITS-1:0]   araddr,
    input  logic                       arvalid,
    output logic                       arready,
    output logic [AXI_DATA_BITS-1:0]   axiRdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  logic                       rready
);

    logic [LATENCY_BITS-1:0] latency;
    logic                    readDone;
    logic                    writeDone;
    logic                    protoError;
    errCause                 protoCause;
    logic                    storeWrite;
    logic [INDEX_BITS-1:0]   storeIndex;
    logic [LINE_BITS-1:0]    storeWdata;
    logic [LINE_BITS-1:0]    storeRdata;

    lineAccessSequencer sequencer0 (
        .clk        (clk),
        .rstN       (rstN),
        .read       (read),
        .write      (write),
        .address    (address),
        .wdata      (wdata),
        .latency    (latency),
        .resp       (resp),
        .rdata      (rdata),
        .readDone   (readDone),
        .writeDone  (writeDone),
        .protoError (protoError),
        .protoCause (protoCause),
        .storeWrite (storeWrite),
        .storeIndex (storeIndex),
        .storeWdata (storeWdata),
        .storeRdata (storeRdata)
    );

    lineStore store0 (
        .clk        (clk),
        .storeWrite (storeWrite),
        .storeIndex (storeIndex),
        .storeWdata (storeWdata),
        .storeRdata (storeRdata)
    );

    memConfigRegs regs0 (
        .clk        (clk),
        .rstN       (rstN),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .axiWdata   (axiWdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .axiRdata   (axiRdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .readDone   (readDone),
        .writeDone  (writeDone),
        .protoError (protoError),
        .protoCause (protoCause),
        .latency    (latency),
        .error      (error)
    );

endmodule

//--- tests/axiLiteHostTasks.svh
// single write, both channels raised together
task axiWrite(input logic [AXI_ADDR_BITS-1:0] addr, input logic [AXI_DATA_BITS-1:0] data,
              output logic [1:0] code);
    @(posedge clk);
    awaddr   <= addr;
    axiWdata <= data;
    wstrb    <= 4'hF;
    awvalid  <= 1'b1;
    wvalid   <= 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    code = bresp;
endtask

// single read, rready is held high by the testbench
task axiRead(input logic [AXI_ADDR_BITS-1:0] addr, output logic [AXI_DATA_BITS-1:0] data,
             output logic [1:0] code);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    data = axiRdata;
    code = rresp;
endtask

//--- tests/physMemTb.sv
`timescale 1ns/1ps

module physMemTb
    import physMemPkg::*;
();

    // latency plus two per planned request, 50 per AXI access, then margin
    localparam int REQ_CYCLES   = 128 * (25 + 2) + 2 * (3 + 2) + (40 + 2) + (3 + 2) + 6 * (10 + 2);
    localparam int AXI_ACCESSES = 3 + 9 + 2 + 5;
    localparam int CYCLE_LIMIT  = REQ_CYCLES + 50 * AXI_ACCESSES + 1000;

    logic                       clk;
    logic                       rstN;
    logic                       read;
    logic                       write;
    logic [ADDR_BITS-1:0]       address;
    logic [LINE_BITS-1:0]       wdata;
    logic                       resp;
    logic [LINE_BITS-1:0]       rdata;
    logic                       error;
    logic [AXI_ADDR_BITS-1:0]   awaddr;
    logic                       awvalid;
    logic                       awready;
    logic [AXI_DATA_BITS-1:0]   axiWdata;
    logic [AXI_DATA_BITS/8-1:0] wstrb;
    logic                       wvalid;
    logic                       wready;
    logic [1:0]                 bresp;
    logic                       bvalid;
    logic                       bready;
    logic [AXI_ADDR_BITS-1:0]   araddr;
    logic                       arvalid;
    logic                       arready;
    logic [AXI_DATA_BITS-1:0]   axiRdata;
    logic [1:0]                 rresp;
    logic                       rvalid;
    logic                       rready;

    logic [LINE_BITS-1:0] shadow [LINE_COUNT];
    integer seed = 32'h9b6ff8b2;
    int numReads = 0;
    int numWrites = 0;
    int cycleCount = 0;

    physMemTop dut0 (.*);

    `include "axiLiteHostTasks.svh"

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    task automatic checkValue(input string name, input logic [LINE_BITS-1:0] actual,
                              input logic [LINE_BITS-1:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    // line index sits in address bits 10:5
    function automatic logic [LINE_BITS-1:0] expectedLine(input logic [ADDR_BITS-1:0] addr);
        return shadow[addr[10:5]];
    endfunction

    function automatic logic [LINE_BITS-1:0] randomLine();
        logic [LINE_BITS-1:0] line;
        for (int w = 0; w < LINE_BITS / 32; w++) begin
            line[w*32 +: 32] = $random(seed);
        end
        return line;
    endfunction

    // random upper and offset bits around a fixed index
    function automatic logic [ADDR_BITS-1:0] addrFor(input int index);
        logic [ADDR_BITS-1:0] addr;
        addr = $random(seed);
        addr[10:5] = index[5:0];
        return addr;
    endfunction

    // compares read data and mirrors writes in the resp cycle
    always @(negedge clk) begin
        if (rstN && resp) begin
            if (read) begin
                checkValue("rdata", rdata, expectedLine(address));
                numReads++;
            end else if (write) begin
                shadow[address[10:5]] = wdata;
                numWrites++;
            end
        end
    end

    task automatic startRequest(input logic isWrite, input logic [ADDR_BITS-1:0] addr,
                                input logic [LINE_BITS-1:0] line);
        @(posedge clk);
        read    <= !isWrite;
        write   <= isWrite;
        address <= addr;
        wdata   <= line;
    endtask

    // cycles from the accepting edge to the edge that raises resp
    task automatic waitResp(output int cycles);
        @(posedge clk);
        cycles = 0;
        @(negedge clk);
        while (!resp) begin
            cycles++;
            @(negedge clk);
        end
    endtask

    task automatic endRequest();
        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
        @(negedge clk);
        checkValue("resp", resp, 1'b0);
    endtask

    task automatic runRequest(input logic isWrite, input logic [ADDR_BITS-1:0] addr,
                              input logic [LINE_BITS-1:0] line, input int expLatency);
        int cycles;
        startRequest(isWrite, addr, line);
        waitResp(cycles);
        checkValue("resp latency", cycles, expLatency);
        endRequest();
    endtask

    task automatic abortRequest(input errCause kind, input logic isWrite,
                                input logic [ADDR_BITS-1:0] addr);
        logic [AXI_DATA_BITS-1:0] status;
        logic [1:0]               code;
        startRequest(isWrite, addr, randomLine());
        repeat (2) @(posedge clk);
        case (kind)
            CAUSE_READ_DROPPED:  read <= 1'b0;
            CAUSE_WRITE_DROPPED: write <= 1'b0;
            CAUSE_CONFLICT:      write <= 1'b1;
            default:             address <= addr ^ 32'h40;
        endcase
        @(posedge clk);
        read  <= 1'b0;
        write <= 1'b0;
        // window is longer than the programmed latency of 10
        repeat (20) begin
            @(negedge clk);
            checkValue("resp", resp, 1'b0);
        end
        checkValue("error", error, 1'b1);
        axiRead(REG_STATUS, status, code);
        checkValue("status", status, {kind, 1'b1});
        checkValue("rresp", code, RESP_OKAY);
        axiWrite(REG_STATUS, 32'h1, code);
        @(negedge clk);
        checkValue("error", error, 1'b0);
    endtask

    initial begin
        int                       cycles;
        logic [1:0]               code;
        logic [AXI_DATA_BITS-1:0] data;
        rstN = 1'b0;
        read = 1'b0;
        write = 1'b0;
        address = '0;
        wdata = '0;
        awaddr = '0;
        awvalid = 1'b0;
        axiWdata = '0;
        wstrb = '0;
        wvalid = 1'b0;
        bready = 1'b1;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b1;
        repeat (16) @(posedge clk);
        rstN <= 1'b1;

        // fill every line, then read each back through other upper bits
        for (int i = 0; i < LINE_COUNT; i++) begin
            runRequest(1'b1, addrFor(i), randomLine(), DEFAULT_LATENCY);
        end
        for (int i = 0; i < LINE_COUNT; i++) begin
            runRequest(1'b0, addrFor(i), '0, DEFAULT_LATENCY);
        end

        axiWrite(REG_LATENCY, 32'd3, code);
        checkValue("bresp", code, RESP_OKAY);
        startRequest(1'b0, addrFor(5), '0);
        waitResp(cycles);
        checkValue("resp latency", cycles, 3);
        // held request waits out the recover cycle, so it lands one edge later
        waitResp(cycles);
        checkValue("back-to-back latency", cycles, 4);
        endRequest();

        axiWrite(REG_LATENCY, 32'd40, code);
        startRequest(1'b1, addrFor(20), randomLine());
        fork
            waitResp(cycles);
            begin
                repeat (4) @(posedge clk);
                axiWrite(REG_LATENCY, 32'd3, code);
            end
        join
        checkValue("in-flight latency", cycles, 40);
        endRequest();
        runRequest(1'b0, addrFor(20), '0, 3);

        axiWrite(REG_LATENCY, 32'd10, code);
        abortRequest(CAUSE_READ_DROPPED, 1'b0, addrFor(7));
        abortRequest(CAUSE_WRITE_DROPPED, 1'b1, addrFor(12));
        runRequest(1'b0, addrFor(12), '0, 10);
        abortRequest(CAUSE_CONFLICT, 1'b0, addrFor(9));
        abortRequest(CAUSE_ADDR_CHANGED, 1'b1, addrFor(33));
        runRequest(1'b0, addrFor(33), '0, 10);

        axiRead(REG_READ_COUNT, data, code);
        checkValue("read count", data, numReads);
        axiRead(REG_WRITE_COUNT, data, code);
        checkValue("write count", data, numWrites);

        // no register above 0xC in the 4-bit offset space
        axiWrite(4'hE, 32'hFFFF_FFFF, code);
        checkValue("bresp", code, RESP_SLVERR);
        axiRead(4'hE, data, code);
        checkValue("rresp", code, RESP_SLVERR);
        checkValue("unmapped rdata", data, 32'h0);
        axiRead(REG_LATENCY, data, code);
        checkValue("latency", data, 32'd10);
        axiRead(REG_READ_COUNT, data, code);
        checkValue("read count", data, numReads);
        axiRead(REG_WRITE_COUNT, data, code);
        checkValue("write count", data, numWrites);

        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+tests
logic/physMemPkg.sv
logic/lineStore.sv
logic/lineAccessSequencer.sv
logic/memConfigRegs.sv
logic/physMemTop.sv
tests/physMemTb.sv
